//--- rtl/core_isa_pkg.sv
package core_isa_pkg;

   // major opcodes of the supported subset
   typedef enum logic [6:0] {
      OPC_OP     = 7'b0110011,
      OPC_OP_IMM = 7'b0010011,
      OPC_LUI    = 7'b0110111,
      OPC_LOAD   = 7'b0000011,
      OPC_STORE  = 7'b0100011,
      OPC_BRANCH = 7'b1100011,
      OPC_JAL    = 7'b1101111
   } opcode_e;

   typedef enum logic [3:0] {
      ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
      ALU_SLT, ALU_SLL, ALU_SRL,
      ALU_PASS_B // lui, operand b straight through
   } alu_op_e;

   typedef enum logic [2:0] {
      BR_NONE, BR_EQ, BR_NE, BR_LT,
      BR_ALWAYS // jal
   } branch_e;

   typedef enum logic [1:0] {
      WB_ALU, WB_LOAD, WB_PC4
   } wb_sel_e;

   // funct3 values
   localparam logic [2:0] F3_ADD  = 3'b000; // add / sub / addi
   localparam logic [2:0] F3_SLL  = 3'b001;
   localparam logic [2:0] F3_SLT  = 3'b010;
   localparam logic [2:0] F3_XOR  = 3'b100;
   localparam logic [2:0] F3_SRL  = 3'b101; // sra shares it, not supported
   localparam logic [2:0] F3_OR   = 3'b110;
   localparam logic [2:0] F3_AND  = 3'b111;
   localparam logic [2:0] F3_WORD = 3'b010; // lw / sw
   localparam logic [2:0] F3_BEQ  = 3'b000;
   localparam logic [2:0] F3_BNE  = 3'b001;
   localparam logic [2:0] F3_BLT  = 3'b100;

   localparam logic [31:0] NOP_INSTR = 32'h0000_0013; // addi x0, x0, 0

endpackage

//--- rtl/core_pipe_pkg.sv
package core_pipe_pkg;

   // operand source in execute
   typedef enum logic [1:0] {
      FWD_REGFILE, FWD_EX_MEM, FWD_MEM_WB
   } fwd_sel_e;

   // decoded controls, 14 bits
   typedef struct packed {
      core_isa_pkg::alu_op_e alu_op;
      core_isa_pkg::branch_e branch;
      core_isa_pkg::wb_sel_e wb_sel;
      logic                  op_a_is_pc;  // alu a = pc
      logic                  op_b_is_imm; // alu b = imm
      logic                  mem_read;
      logic                  mem_write;
      logic                  reg_we;
   } ctrl_t;

   // bubble, nothing written anywhere
   localparam ctrl_t CTRL_BUBBLE = '{
      alu_op: core_isa_pkg::ALU_ADD, branch: core_isa_pkg::BR_NONE,
      wb_sel: core_isa_pkg::WB_ALU, default: 1'b0
   };

endpackage

//--- rtl/ex_bus_if.sv
`timescale 1ns/10ps

// id/ex register contents, decode to execute
interface ex_bus_if;

   core_pipe_pkg::ctrl_t ctrl;
   logic [31:0]          pc;
   logic [31:0]          rs1_val;
   logic [31:0]          rs2_val;
   logic [31:0]          imm;
   logic [4:0]           rs1_addr; // kept for forwarding
   logic [4:0]           rs2_addr;
   logic [4:0]           rd_addr;

   modport dec_mp (
      output ctrl, pc, rs1_val, rs2_val, imm, rs1_addr, rs2_addr, rd_addr
   );

   modport ex_mp (
      input ctrl, pc, rs1_val, rs2_val, imm, rs1_addr, rs2_addr, rd_addr
   );

endinterface

//--- rtl/fetch_stage.sv
`timescale 1ns/10ps

module fetch_stage #(
   parameter logic [31:0] RESET_PC = 32'h0
) (
   input  logic        clk_i,
   input  logic        arst_n_i,
   input  logic        stall_i,
   input  logic        redirect_i,
   input  logic [31:0] redirect_pc_i,
   input  logic [31:0] instr_data_i,
   output logic [31:0] instr_addr_o,
   output logic [31:0] if_pc_o,
   output logic [31:0] if_instr_o
);

   logic [31:0] pc_q;
   logic [31:0] pc_next;

   // redirect beats stall
   always_comb begin
      if (redirect_i)
         pc_next = redirect_pc_i;
      else if (stall_i)
         pc_next = pc_q; // hold
      else
         pc_next = pc_q + 32'd4;
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         pc_q       <= RESET_PC;
         if_pc_o    <= RESET_PC;
         if_instr_o <= core_isa_pkg::NOP_INSTR; // if/id starts empty
      end else begin
         pc_q <= pc_next;
         if (redirect_i) begin
            if_instr_o <= core_isa_pkg::NOP_INSTR; // squash wrong-path fetch
         end else if (!stall_i) begin
            if_pc_o    <= pc_q;
            if_instr_o <= instr_data_i;
         end
      end
   end

   assign instr_addr_o = pc_q; // memory answers same cycle

endmodule

//--- rtl/reg_file.sv
`timescale 1ns/10ps

module reg_file (
   input  logic        clk_i,
   input  logic        arst_n_i,
   input  logic [4:0]  rs1_addr_i,
   input  logic [4:0]  rs2_addr_i,
   input  logic [4:0]  wr_addr_i,
   input  logic        wr_en_i,
   input  logic [31:0] wr_data_i,
   output logic [31:0] rs1_data_o,
   output logic [31:0] rs2_data_o
);

   logic [31:0] regs [1:31]; // no storage for x0

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i)
         regs <= '{default: 32'h0};
      else if (wr_en_i && wr_addr_i != 5'd0)
         regs[wr_addr_i] <= wr_data_i;
   end

   // x0 reads zero, same-cycle write bypasses the array
   function automatic logic [31:0] read_port(input logic [4:0] addr);
      if (addr == 5'd0)
         return 32'h0;
      else if (wr_en_i && wr_addr_i == addr)
         return wr_data_i;
      return regs[addr];
   endfunction

   always_comb begin
      rs1_data_o = read_port(rs1_addr_i);
      rs2_data_o = read_port(rs2_addr_i);
   end

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
   input  logic        clk_i,
   input  logic        arst_n_i,
   input  logic [31:0] if_pc_i,
   input  logic [31:0] if_instr_i,
   input  logic        redirect_i,
   input  logic        wb_we_i,
   input  logic [4:0]  wb_rd_i,
   input  logic [31:0] wb_data_i,
   output logic        stall_o,
   ex_bus_if.dec_mp    ex_o
);

   core_isa_pkg::opcode_e opcode;
   core_pipe_pkg::ctrl_t  ctrl;
   logic [4:0]  rs1_addr, rs2_addr, rd_addr;
   logic [2:0]  funct3;
   logic        funct7_b5; // sub / sra flag
   logic [31:0] rs1_val, rs2_val;
   logic [31:0] imm;
   logic        uses_rs1, uses_rs2;
   logic        illegal;

   assign opcode    = core_isa_pkg::opcode_e'(if_instr_i[6:0]);
   assign rd_addr   = if_instr_i[11:7];
   assign funct3    = if_instr_i[14:12];
   assign rs1_addr  = if_instr_i[19:15];
   assign rs2_addr  = if_instr_i[24:20];
   assign funct7_b5 = if_instr_i[30];

   reg_file u_reg_file (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .rs1_addr_i (rs1_addr),
      .rs2_addr_i (rs2_addr),
      .wr_addr_i  (wb_rd_i),
      .wr_en_i    (wb_we_i),
      .wr_data_i  (wb_data_i),
      .rs1_data_o (rs1_val),
      .rs2_data_o (rs2_val)
   );

   // immediate by format, i-type otherwise
   always_comb begin
      case (opcode)
         core_isa_pkg::OPC_STORE:
            imm = {{20{if_instr_i[31]}}, if_instr_i[31:25], if_instr_i[11:7]};
         core_isa_pkg::OPC_BRANCH:
            imm = {{20{if_instr_i[31]}}, if_instr_i[7], if_instr_i[30:25],
                   if_instr_i[11:8], 1'b0};
         core_isa_pkg::OPC_LUI:
            imm = {if_instr_i[31:12], 12'h0};
         core_isa_pkg::OPC_JAL:
            imm = {{12{if_instr_i[31]}}, if_instr_i[19:12], if_instr_i[20],
                   if_instr_i[30:21], 1'b0};
         default:
            imm = {{21{if_instr_i[31]}}, if_instr_i[30:20]};
      endcase
   end

   always_comb begin
      ctrl     = core_pipe_pkg::CTRL_BUBBLE;
      uses_rs1 = 1'b0;
      uses_rs2 = 1'b0;
      illegal  = 1'b0;
      case (opcode)
         core_isa_pkg::OPC_OP, core_isa_pkg::OPC_OP_IMM: begin
            ctrl.reg_we      = 1'b1;
            ctrl.op_b_is_imm = (opcode == core_isa_pkg::OPC_OP_IMM);
            uses_rs1         = 1'b1;
            uses_rs2         = (opcode == core_isa_pkg::OPC_OP);
            case (funct3)
               core_isa_pkg::F3_ADD: // no subi
                  ctrl.alu_op = (funct7_b5 && uses_rs2) ? core_isa_pkg::ALU_SUB
                                                        : core_isa_pkg::ALU_ADD;
               core_isa_pkg::F3_SLL: ctrl.alu_op = core_isa_pkg::ALU_SLL;
               core_isa_pkg::F3_SLT: ctrl.alu_op = core_isa_pkg::ALU_SLT;
               core_isa_pkg::F3_XOR: ctrl.alu_op = core_isa_pkg::ALU_XOR;
               core_isa_pkg::F3_SRL: begin
                  ctrl.alu_op = core_isa_pkg::ALU_SRL;
                  illegal     = funct7_b5; // sra / srai
               end
               core_isa_pkg::F3_OR:  ctrl.alu_op = core_isa_pkg::ALU_OR;
               core_isa_pkg::F3_AND: ctrl.alu_op = core_isa_pkg::ALU_AND;
               default:              illegal = 1'b1; // sltu
            endcase
         end
         core_isa_pkg::OPC_LUI: begin
            ctrl.reg_we      = 1'b1;
            ctrl.op_b_is_imm = 1'b1;
            ctrl.alu_op      = core_isa_pkg::ALU_PASS_B;
         end
         core_isa_pkg::OPC_LOAD: begin
            ctrl.reg_we      = 1'b1;
            ctrl.mem_read    = 1'b1;
            ctrl.op_b_is_imm = 1'b1; // address rs1 + imm
            ctrl.wb_sel      = core_isa_pkg::WB_LOAD;
            uses_rs1         = 1'b1;
            illegal          = (funct3 != core_isa_pkg::F3_WORD); // lw only
         end
         core_isa_pkg::OPC_STORE: begin
            ctrl.mem_write   = 1'b1;
            ctrl.op_b_is_imm = 1'b1;
            uses_rs1         = 1'b1;
            uses_rs2         = 1'b1; // store data
            illegal          = (funct3 != core_isa_pkg::F3_WORD);
         end
         core_isa_pkg::OPC_BRANCH: begin
            ctrl.op_a_is_pc  = 1'b1; // alu makes the target
            ctrl.op_b_is_imm = 1'b1;
            uses_rs1         = 1'b1;
            uses_rs2         = 1'b1;
            case (funct3)
               core_isa_pkg::F3_BEQ: ctrl.branch = core_isa_pkg::BR_EQ;
               core_isa_pkg::F3_BNE: ctrl.branch = core_isa_pkg::BR_NE;
               core_isa_pkg::F3_BLT: ctrl.branch = core_isa_pkg::BR_LT;
               default:              illegal = 1'b1;
            endcase
         end
         core_isa_pkg::OPC_JAL: begin
            ctrl.reg_we      = 1'b1;
            ctrl.op_a_is_pc  = 1'b1;
            ctrl.op_b_is_imm = 1'b1;
            ctrl.branch      = core_isa_pkg::BR_ALWAYS;
            ctrl.wb_sel      = core_isa_pkg::WB_PC4; // link
         end
         default: ; // unknown opcode, nop
      endcase
      if (illegal) begin
         ctrl     = core_pipe_pkg::CTRL_BUBBLE;
         uses_rs1 = 1'b0;
         uses_rs2 = 1'b0;
      end
   end

   // load in id/ex feeding a source here, wait one cycle
   assign stall_o = ex_o.ctrl.mem_read && (ex_o.rd_addr != 5'd0) &&
                    ((uses_rs1 && rs1_addr == ex_o.rd_addr) ||
                     (uses_rs2 && rs2_addr == ex_o.rd_addr));

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i)
         ex_o.ctrl <= core_pipe_pkg::CTRL_BUBBLE;
      else if (redirect_i || stall_o)
         ex_o.ctrl <= core_pipe_pkg::CTRL_BUBBLE; // bubble into execute
      else
         ex_o.ctrl <= ctrl;
   end

   always_ff @(posedge clk_i) begin
      ex_o.pc       <= if_pc_i;
      ex_o.rs1_val  <= rs1_val;
      ex_o.rs2_val  <= rs2_val;
      ex_o.imm      <= imm;
      ex_o.rs1_addr <= rs1_addr;
      ex_o.rs2_addr <= rs2_addr;
      ex_o.rd_addr  <= rd_addr;
   end

endmodule

//--- rtl/execute_stage.sv
`timescale 1ns/10ps

module execute_stage (
   input  logic                 clk_i,
   input  logic                 arst_n_i,
   ex_bus_if.ex_mp              ex_i,
   input  logic                 wb_we_i,
   input  logic [4:0]           wb_rd_i,
   input  logic [31:0]          wb_data_i,
   output logic                 redirect_o,
   output logic [31:0]          redirect_pc_o,
   output core_pipe_pkg::ctrl_t mem_ctrl_o,
   output logic [31:0]          mem_alu_o,
   output logic [31:0]          mem_store_o,
   output logic [31:0]          mem_pc_o,
   output logic [4:0]           mem_rd_o
);

   core_pipe_pkg::fwd_sel_e fwd_a, fwd_b;
   logic [31:0] rs1_fwd, rs2_fwd;
   logic [31:0] op_a, op_b;
   logic [31:0] alu_res;
   logic        taken;

   // ex/mem first, then mem/wb; x0 never forwards
   function automatic core_pipe_pkg::fwd_sel_e pick_src(input logic [4:0] addr);
      if (addr != 5'd0 && mem_ctrl_o.reg_we && mem_rd_o == addr &&
          mem_ctrl_o.wb_sel == core_isa_pkg::WB_ALU) // not a load or a link
         return core_pipe_pkg::FWD_EX_MEM;
      else if (addr != 5'd0 && wb_we_i && wb_rd_i == addr)
         return core_pipe_pkg::FWD_MEM_WB;
      return core_pipe_pkg::FWD_REGFILE;
   endfunction

   function automatic logic [31:0] src_val(input core_pipe_pkg::fwd_sel_e sel,
                                           input logic [31:0] rf_val);
      case (sel)
         core_pipe_pkg::FWD_EX_MEM: return mem_alu_o;
         core_pipe_pkg::FWD_MEM_WB: return wb_data_i;
         default:                   return rf_val;
      endcase
   endfunction

   always_comb begin
      fwd_a   = pick_src(ex_i.rs1_addr);
      fwd_b   = pick_src(ex_i.rs2_addr);
      rs1_fwd = src_val(fwd_a, ex_i.rs1_val);
      rs2_fwd = src_val(fwd_b, ex_i.rs2_val);
      op_a    = ex_i.ctrl.op_a_is_pc ? ex_i.pc : rs1_fwd;
      op_b    = ex_i.ctrl.op_b_is_imm ? ex_i.imm : rs2_fwd;
   end

   always_comb begin
      case (ex_i.ctrl.alu_op)
         core_isa_pkg::ALU_SUB:    alu_res = op_a - op_b;
         core_isa_pkg::ALU_AND:    alu_res = op_a & op_b;
         core_isa_pkg::ALU_OR:     alu_res = op_a | op_b;
         core_isa_pkg::ALU_XOR:    alu_res = op_a ^ op_b;
         core_isa_pkg::ALU_SLT:    alu_res = {31'h0, $signed(op_a) < $signed(op_b)};
         core_isa_pkg::ALU_SLL:    alu_res = op_a << op_b[4:0];
         core_isa_pkg::ALU_SRL:    alu_res = op_a >> op_b[4:0];
         core_isa_pkg::ALU_PASS_B: alu_res = op_b; // lui
         default:                  alu_res = op_a + op_b;
      endcase
   end

   // compare always on the register values
   always_comb begin
      case (ex_i.ctrl.branch)
         core_isa_pkg::BR_EQ:     taken = (rs1_fwd == rs2_fwd);
         core_isa_pkg::BR_NE:     taken = (rs1_fwd != rs2_fwd);
         core_isa_pkg::BR_LT:     taken = ($signed(rs1_fwd) < $signed(rs2_fwd));
         core_isa_pkg::BR_ALWAYS: taken = 1'b1;
         default:                 taken = 1'b0;
      endcase
   end

   assign redirect_o    = taken;
   assign redirect_pc_o = alu_res; // pc + imm

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i)
         mem_ctrl_o <= core_pipe_pkg::CTRL_BUBBLE;
      else
         mem_ctrl_o <= ex_i.ctrl;
   end

   always_ff @(posedge clk_i) begin
      mem_alu_o   <= alu_res;
      mem_store_o <= rs2_fwd; // forwarded store data
      mem_pc_o    <= ex_i.pc;
      mem_rd_o    <= ex_i.rd_addr;
   end

endmodule

//--- rtl/memory_stage.sv
`timescale 1ns/10ps

module memory_stage (
   input  logic                 clk_i,
   input  logic                 arst_n_i,
   input  core_pipe_pkg::ctrl_t mem_ctrl_i,
   input  logic [31:0]          mem_alu_i,
   input  logic [31:0]          mem_store_i,
   input  logic [31:0]          mem_pc_i,
   input  logic [4:0]           mem_rd_i,
   input  logic [31:0]          data_rdata_i,
   output logic [31:0]          data_addr_o,
   output logic [31:0]          data_wdata_o,
   output logic                 data_we_o,
   output logic                 wb_we_o,
   output logic [4:0]           wb_rd_o,
   output logic [31:0]          wb_data_o
);

   logic [31:0] wb_val;

   // data bus straight from ex/mem
   assign data_addr_o  = mem_alu_i;
   assign data_wdata_o = mem_store_i;
   assign data_we_o    = mem_ctrl_i.mem_write; // one cycle per store

   always_comb begin
      case (mem_ctrl_i.wb_sel)
         core_isa_pkg::WB_LOAD: wb_val = data_rdata_i;
         core_isa_pkg::WB_PC4:  wb_val = mem_pc_i + 32'd4; // jal link
         default:               wb_val = mem_alu_i;
      endcase
   end

   // mem/wb, wb itself is wires only
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i)
         wb_we_o <= 1'b0;
      else
         wb_we_o <= mem_ctrl_i.reg_we;
   end

   always_ff @(posedge clk_i) begin
      wb_rd_o   <= mem_rd_i;
      wb_data_o <= wb_val;
   end

endmodule

//--- rtl/core.sv
`timescale 1ns/10ps

module core #(
   parameter logic [31:0] RESET_PC = 32'h0
) (
   input  logic        clk_i,
   input  logic        arst_n_i,
   input  logic [31:0] instr_data_i,
   input  logic [31:0] data_rdata_i,
   output logic [31:0] instr_addr_o,
   output logic [31:0] data_addr_o,
   output logic [31:0] data_wdata_o,
   output logic        data_we_o
);

   // fetch / decode / execute links
   logic        stall;
   logic        redirect;
   logic [31:0] redirect_pc;
   logic [31:0] if_pc, if_instr;

   // ex/mem register
   core_pipe_pkg::ctrl_t mem_ctrl;
   logic [31:0] mem_alu, mem_store, mem_pc;
   logic [4:0]  mem_rd;

   // mem/wb register, write port and forward source
   logic        wb_we;
   logic [4:0]  wb_rd;
   logic [31:0] wb_data;

   ex_bus_if u_ex_bus ();

   fetch_stage #(.RESET_PC(RESET_PC)) u_if (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .stall_i       (stall),
      .redirect_i    (redirect),
      .redirect_pc_i (redirect_pc),
      .instr_data_i  (instr_data_i),
      .instr_addr_o  (instr_addr_o),
      .if_pc_o       (if_pc),
      .if_instr_o    (if_instr)
   );

   decode_stage u_id (
      .clk_i      (clk_i),
      .arst_n_i   (arst_n_i),
      .if_pc_i    (if_pc),
      .if_instr_i (if_instr),
      .redirect_i (redirect),
      .wb_we_i    (wb_we),
      .wb_rd_i    (wb_rd),
      .wb_data_i  (wb_data),
      .stall_o    (stall),
      .ex_o       (u_ex_bus.dec_mp)
   );

   execute_stage u_ex (
      .clk_i         (clk_i),
      .arst_n_i      (arst_n_i),
      .ex_i          (u_ex_bus.ex_mp),
      .wb_we_i       (wb_we),
      .wb_rd_i       (wb_rd),
      .wb_data_i     (wb_data),
      .redirect_o    (redirect),
      .redirect_pc_o (redirect_pc),
      .mem_ctrl_o    (mem_ctrl),
      .mem_alu_o     (mem_alu),
      .mem_store_o   (mem_store),
      .mem_pc_o      (mem_pc),
      .mem_rd_o      (mem_rd)
   );

   memory_stage u_mem (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .mem_ctrl_i   (mem_ctrl),
      .mem_alu_i    (mem_alu),
      .mem_store_i  (mem_store),
      .mem_pc_i     (mem_pc),
      .mem_rd_i     (mem_rd),
      .data_rdata_i (data_rdata_i),
      .data_addr_o  (data_addr_o),
      .data_wdata_o (data_wdata_o),
      .data_we_o    (data_we_o),
      .wb_we_o      (wb_we),
      .wb_rd_o      (wb_rd),
      .wb_data_o    (wb_data)
   );

endmodule

//--- dv/core_sva.sv
`timescale 1ns/10ps

module core_sva (
   input logic        clk_i,
   input logic        arst_n_i,
   input logic        data_we_i,
   input logic [31:0] instr_addr_i,
   input logic        stall_i,
   input logic        redirect_i,
   input logic        mem_read_i
);

   // no store strobe while the pipeline sits in reset
   a_no_store_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !data_we_i)
      else $error("data_we_o high during reset");

   a_fetch_aligned: assert property (@(posedge clk_i) instr_addr_i[1:0] == 2'b00)
      else $error("instr_addr_o not word aligned");

   // load-use interlock freezes the pc, a redirect overrides it
   a_pc_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (stall_i && !redirect_i) |=> $stable(instr_addr_i))
      else $error("pc moved during a stall");

   a_store_not_load: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !(data_we_i && mem_read_i))
      else $error("store strobe together with a load in the memory stage");

endmodule

bind core core_sva u_core_sva (
   .clk_i        (clk_i),
   .arst_n_i     (arst_n_i),
   .data_we_i    (data_we_o),
   .instr_addr_i (instr_addr_o),  // pc register of fetch
   .stall_i      (stall),
   .redirect_i   (redirect),
   .mem_read_i   (mem_ctrl.mem_read)
);

//--- dv/core_tb.sv
`timescale 1ns/10ps

module core_tb;

   localparam int NROWS      = 5;
   localparam int MAXLEN     = 32;
   localparam int MAXST      = 8;
   localparam int RST_CYCLES = 10;
   localparam int DRAIN      = 8;  // quiet cycles after the last store
   localparam logic [31:0] START_PC = 32'h0;

   logic        clk_i    = 1'b0;
   logic        arst_n_i = 1'b0;
   logic [31:0] instr_data_i;
   logic [31:0] data_rdata_i;
   logic [31:0] instr_addr_o;
   logic [31:0] data_addr_o;
   logic [31:0] data_wdata_o;
   logic        data_we_o;

   logic [31:0] imem [0:63]  = '{default: 32'h0};
   logic [31:0] dmem [0:255] = '{default: 32'h0};
   logic [31:0] bg   [0:255]; // random background, loads read it

   // program table, one row per test
   string       names    [NROWS];
   logic [31:0] prog     [NROWS][MAXLEN];
   int          plen     [NROWS];
   logic [31:0] exp_addr [NROWS][MAXST];
   logic [31:0] exp_data [NROWS][MAXST];
   int          ecnt     [NROWS];
   int          cur         = 0;
   int          total_cyc   = 0;
   int          total_limit = 0;

   always #2 clk_i = ~clk_i;

   core #(.RESET_PC(START_PC)) dut_i (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .instr_data_i (instr_data_i),
      .data_rdata_i (data_rdata_i),
      .instr_addr_o (instr_addr_o),
      .data_addr_o  (data_addr_o),
      .data_wdata_o (data_wdata_o),
      .data_we_o    (data_we_o)
   );

   // both memories answer in the same cycle
   assign instr_data_i = imem[instr_addr_o[7:2]];
   assign data_rdata_i = dmem[data_addr_o[9:2]];

   always @(posedge clk_i) begin
      if (!arst_n_i) begin
         for (int i = 0; i < 256; i++)
            dmem[i] <= bg[i]; // fresh data memory for every row
      end else if (data_we_o) begin
         dmem[data_addr_o[9:2]] <= data_wdata_o;
      end
   end

   // whole-run watchdog
   always @(posedge clk_i) begin
      total_cyc <= total_cyc + 1;
      if (total_limit > 0 && total_cyc >= total_limit) begin
         $display("run stopped after %0d cycles without finishing", total_cyc);
         $display("Test failures found");
         $finish;
      end
   end

   // rv32i encodings
   function automatic logic [31:0] reg_op(input int f7, input int f3, input int rd,
                                          input int rs1, input int rs2);
      return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], core_isa_pkg::OPC_OP};
   endfunction

   function automatic logic [31:0] imm_op(input int f3, input int rd, input int rs1,
                                          input int imm);
      return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], core_isa_pkg::OPC_OP_IMM};
   endfunction

   function automatic logic [31:0] load_word(input int rd, input int rs1, input int imm);
      return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], core_isa_pkg::OPC_LOAD};
   endfunction

   function automatic logic [31:0] store_word(input int rs2, input int rs1, input int imm);
      return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], core_isa_pkg::OPC_STORE};
   endfunction

   function automatic logic [31:0] branch_to(input int f3, input int rs1, input int rs2,
                                             input int off);
      return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
              core_isa_pkg::OPC_BRANCH};
   endfunction

   function automatic logic [31:0] upper_imm(input int rd, input int imm20);
      return {imm20[19:0], rd[4:0], core_isa_pkg::OPC_LUI};
   endfunction

   function automatic logic [31:0] jump_link(input int rd, input int off);
      return {off[20], off[10:1], off[11], off[19:12], rd[4:0], core_isa_pkg::OPC_JAL};
   endfunction

   task automatic new_row(input int row, input string name);
      cur        = row;
      names[row] = name;
      plen[row]  = 0;
      ecnt[row]  = 0;
   endtask

   task automatic push_instr(input logic [31:0] instr);
      prog[cur][plen[cur]] = instr;
      plen[cur]            = plen[cur] + 1;
   endtask

   task automatic want_store(input logic [31:0] addr, input logic [31:0] data);
      exp_addr[cur][ecnt[cur]] = addr;
      exp_data[cur][ecnt[cur]] = data;
      ecnt[cur]                = ecnt[cur] + 1;
   endtask

   task automatic build_table();
      new_row(0, "alu_chain");
      push_instr(imm_op(0, 1, 0, 5));             // addi x1,x0,5
      push_instr(imm_op(0, 2, 1, 7));             // addi x2,x1,7    12
      push_instr(reg_op(0, 0, 3, 2, 1));          // add  x3,x2,x1   17
      push_instr(reg_op(32, 0, 4, 3, 1));         // sub  x4,x3,x1   12
      push_instr(imm_op(1, 5, 4, 3));             // slli x5,x4,3    0x60
      push_instr(reg_op(0, 4, 6, 5, 3));          // xor  x6,x5,x3   0x71
      push_instr(reg_op(0, 6, 7, 6, 2));          // or   x7,x6,x2   0x7d
      push_instr(reg_op(0, 7, 8, 7, 5));          // and  x8,x7,x5   0x60
      push_instr(imm_op(5, 9, 7, 2));             // srli x9,x7,2    0x1f
      push_instr(imm_op(0, 11, 0, -3));           // addi x11,x0,-3
      push_instr(reg_op(0, 2, 10, 11, 1));        // slt  x10,x11,x1 signed, 1
      push_instr(reg_op(0, 1, 12, 1, 10));        // sll  x12,x1,x10 10
      push_instr(imm_op(7, 13, 11, 'hf0));        // andi x13,x11,0xf0
      push_instr(imm_op(6, 14, 9, 'h100));        // ori  x14,x9,0x100
      push_instr(imm_op(4, 15, 14, -1));          // xori x15,x14,-1
      push_instr(store_word(3, 0, 0));
      push_instr(store_word(6, 0, 4));
      push_instr(store_word(8, 0, 8));
      push_instr(store_word(9, 0, 12));
      push_instr(store_word(10, 0, 16));
      push_instr(store_word(12, 0, 20));
      push_instr(store_word(15, 0, 24));
      push_instr(store_word(13, 0, 28));
      push_instr(jump_link(0, 0));                // park here
      want_store(32'h00, 32'd17);
      want_store(32'h04, 32'h71);
      want_store(32'h08, 32'h60);
      want_store(32'h0c, 32'h1f);
      want_store(32'h10, 32'd1);
      want_store(32'h14, 32'd10);
      want_store(32'h18, 32'hffff_fee0);
      want_store(32'h1c, 32'hf0);

      new_row(1, "load_use");
      push_instr(imm_op(0, 3, 0, 'h123));         // addend
      push_instr(load_word(1, 0, 128));
      push_instr(reg_op(0, 0, 2, 1, 3));          // uses load right away
      push_instr(store_word(2, 0, 0));
      push_instr(load_word(4, 0, 132));
      push_instr(store_word(4, 0, 4));            // load feeds store data
      push_instr(load_word(5, 0, 136));
      push_instr(imm_op(0, 7, 0, 1));
      push_instr(reg_op(32, 0, 6, 5, 7));         // load from mem/wb, no stall
      push_instr(store_word(6, 0, 8));
      push_instr(jump_link(0, 0));
      want_store(32'h00, bg[32] + 32'h123);
      want_store(32'h04, bg[33]);
      want_store(32'h08, bg[34] - 32'd1);

      new_row(2, "branches");
      push_instr(imm_op(0, 1, 0, 1));
      push_instr(imm_op(0, 2, 0, 2));
      push_instr(branch_to(0, 1, 2, 12));         // beq, not taken
      push_instr(store_word(1, 0, 0));
      push_instr(branch_to(0, 1, 1, 12));         // beq, taken to 7
      push_instr(store_word(2, 0, 4));            // shadow
      push_instr(store_word(2, 0, 8));            // shadow
      push_instr(branch_to(1, 1, 1, 8));          // bne, not taken
      push_instr(store_word(2, 0, 12));
      push_instr(branch_to(1, 1, 2, 12));         // bne, taken to 12
      push_instr(store_word(1, 0, 16));
      push_instr(store_word(1, 0, 20));
      push_instr(imm_op(0, 3, 0, -1));
      push_instr(branch_to(4, 3, 1, 12));         // blt -1 < 1, taken to 16
      push_instr(store_word(3, 0, 24));
      push_instr(store_word(3, 0, 28));
      push_instr(branch_to(4, 1, 3, 8));          // blt 1 < -1, not taken
      push_instr(store_word(3, 0, 32));
      push_instr(jump_link(0, 0));
      want_store(32'h00, 32'd1);
      want_store(32'h0c, 32'd2);
      want_store(32'h20, 32'hffff_ffff);

      new_row(3, "jal_lui");
      push_instr(upper_imm(1, 'h12345));
      push_instr(jump_link(2, 12));               // pc 4, link 8, to 16
      push_instr(store_word(1, 0, 0));
      push_instr(store_word(1, 0, 4));
      push_instr(store_word(2, 0, 8));
      push_instr(store_word(1, 0, 12));
      push_instr(upper_imm(3, 'hfffff));
      push_instr(imm_op(0, 4, 3, 'h34));
      push_instr(store_word(3, 0, 16));
      push_instr(store_word(4, 0, 20));
      push_instr(jump_link(0, 0));
      want_store(32'h08, 32'd8);
      want_store(32'h0c, 32'h1234_5000);
      want_store(32'h10, 32'hffff_f000);
      want_store(32'h14, 32'hffff_f034);

      new_row(4, "x0_reset");
      push_instr(store_word(0, 0, 'h44));         // first fetch at the reset pc
      push_instr(imm_op(0, 1, 0, 'h66));
      push_instr(imm_op(0, 0, 1, 'h55));          // write to x0
      push_instr(store_word(0, 0, 'h48));
      push_instr(reg_op(0, 0, 0, 1, 1));
      push_instr(upper_imm(0, 'h12345));
      push_instr(store_word(0, 0, 'h4c));
      push_instr(store_word(1, 0, 'h50));
      push_instr(jump_link(0, 0));
      want_store(32'h44, 32'h0);
      want_store(32'h48, 32'h0);
      want_store(32'h4c, 32'h0);
      want_store(32'h50, 32'h66);
   endtask

   function automatic int run_limit();
      int sum;
      sum = 16;
      for (int r = 0; r < NROWS; r++)
         sum = sum + RST_CYCLES + 2 + 40 * plen[r] + DRAIN;
      return sum;
   endfunction

   task automatic load_program(input int row);
      for (int i = 0; i < 64; i++)
         imem[i] = (i < plen[row]) ? prog[row][i] : imm_op(0, 0, 0, 0);
   endtask

   task automatic check_store(input int row, input int idx, inout bit ok);
      assert (data_addr_o == exp_addr[row][idx]) else begin
         $display("[FAIL] %s store %0d: data_addr_o = %h, expected %h",
                  names[row], idx, data_addr_o, exp_addr[row][idx]);
         ok = 1'b0;
      end
      assert (data_wdata_o == exp_data[row][idx]) else begin
         $display("[FAIL] %s store %0d: data_wdata_o = %h, expected %h",
                  names[row], idx, data_wdata_o, exp_data[row][idx]);
         ok = 1'b0;
      end
   endtask

   initial begin
      int seen;
      int cyc;
      int limit;
      int n_pass;
      int n_fail;
      bit ok;
      n_pass = 0;
      n_fail = 0;
      void'($urandom(81));
      for (int i = 0; i < 256; i++)
         bg[i] = $urandom();
      build_table();
      total_limit = run_limit();
      for (int row = 0; row < NROWS; row++) begin
         @(posedge clk_i);
         arst_n_i <= 1'b0;
         @(negedge clk_i);
         ok = 1'b1;
         load_program(row); // core held in reset
         // fetch sits at the reset pc while reset is held
         assert (instr_addr_o == START_PC) else begin
            $display("[FAIL] %s reset: instr_addr_o = %h, expected %h",
                     names[row], instr_addr_o, START_PC);
            ok = 1'b0;
         end
         repeat (RST_CYCLES) @(posedge clk_i);
         arst_n_i <= 1'b1;
         seen  = 0;
         cyc   = 0;
         limit = 40 * plen[row];
         while (seen < ecnt[row] && cyc < limit) begin
            @(negedge clk_i); // outputs settled mid-cycle
            cyc = cyc + 1;
            if (data_we_o) begin
               check_store(row, seen, ok);
               seen = seen + 1;
            end
         end
         assert (seen == ecnt[row]) else begin
            $display("%s: only %0d of %0d stores seen within %0d cycles",
                     names[row], seen, ecnt[row], limit);
            ok = 1'b0;
         end
         repeat (DRAIN) begin
            @(negedge clk_i);
            assert (!data_we_o) else begin
               $display("%s: extra store to address %h", names[row], data_addr_o);
               ok = 1'b0;
            end
         end
         if (ok)
            n_pass = n_pass + 1;
         else
            n_fail = n_fail + 1;
         $display("test %0d %s: %s, %0d of %0d stores, %0d cycles", row, names[row],
                  ok ? "ok" : "FAILED", seen, ecnt[row], cyc);
      end
      $display("%0d tests, %0d passed, %0d failed", NROWS, n_pass, n_fail);
      if (n_fail == 0)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

//--- flist.f
rtl/core_isa_pkg.sv
rtl/core_pipe_pkg.sv
rtl/ex_bus_if.sv
rtl/fetch_stage.sv
rtl/reg_file.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/core.sv
dv/core_sva.sv
dv/core_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module core_tb -f flist.f \
   --Mdir obj_dir -o core_sim

./obj_dir/core_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All tests passed!" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi
